// File: rvCorePkg.sv
`default_nettype none

package rvCorePkg;

	// Major opcodes handled by this slice
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_OP_IMM = 7'b0010011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_SLL   = 4'd2,
		ALU_SLT   = 4'd3,
		ALU_SLTU  = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SRA   = 4'd7,
		ALU_OR    = 4'd8,
		ALU_AND   = 4'd9,
		ALU_PASSB = 4'd10
	} aluOp_e;

	// Access size from the low two bits of funct3
	typedef enum logic [1:0] {
		MEM_B = 2'd0,
		MEM_H = 2'd1,
		MEM_W = 2'd2
	} memSize_e;

	// R and I layout where imm[11:0] is {funct7, rs2}
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} riFields_t;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		logic [6:0] opcode;
	} sFields_t;

	typedef union packed {
		riFields_t ri;
		sFields_t s;
	} instrWord_u;

endpackage

`default_nettype wire

// File: instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
	input wire [31:0] instr,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [31:0] imm,
	output rvCorePkg::aluOp_e aluOp,
	output logic aluSrcImm,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output rvCorePkg::memSize_e memSize,
	output logic illegal
);
	import rvCorePkg::*;

	instrWord_u word;
	logic [31:0] immI, immS, immU;
	logic useRs1, useRs2;
	logic [2:0] f3;
	logic [6:0] f7;

	// ALU op for funct3 when funct7 selects the base variant
	function automatic aluOp_e baseOp(input logic [2:0] fn3);
		case (fn3)
			3'b000: return ALU_ADD;
			3'b001: return ALU_SLL;
			3'b010: return ALU_SLT;
			3'b011: return ALU_SLTU;
			3'b100: return ALU_XOR;
			3'b101: return ALU_SRL;
			3'b110: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign word = instr;
	assign f3 = word.ri.funct3;
	assign f7 = word.ri.funct7;

	assign immI = {{20{word.ri.funct7[6]}}, word.ri.funct7, word.ri.rs2};
	assign immS = {{20{word.s.immHi[6]}}, word.s.immHi, word.s.immLo};
	assign immU = {word.ri.funct7, word.ri.rs2, word.ri.rs1, word.ri.funct3, 12'b0};

	// Unused source fields read as x0 so they never trigger forwarding
	assign rs1 = useRs1 ? word.ri.rs1 : 5'd0;
	assign rs2 = useRs2 ? word.ri.rs2 : 5'd0;
	assign rd = word.ri.rd;

	always_comb begin
		aluOp = ALU_ADD;
		aluSrcImm = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memSize = MEM_W;
		illegal = 1'b0;
		imm = 32'd0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;

		case (word.ri.opcode)
			OPC_OP: begin
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				regWrite = 1'b1;
				if (f7 == 7'b0000000)
					aluOp = baseOp(f3);
				else if (f7 == 7'b0100000 && f3 == 3'b000)
					aluOp = ALU_SUB;
				else if (f7 == 7'b0100000 && f3 == 3'b101)
					aluOp = ALU_SRA;
				else
					illegal = 1'b1;
			end
			OPC_OP_IMM: begin
				useRs1 = 1'b1;
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
				imm = immI;
				aluOp = baseOp(f3);
				// Shift immediates carry a funct7 in the upper bits
				if (f3 == 3'b001 && f7 != 7'b0000000)
					illegal = 1'b1;
				else if (f3 == 3'b101 && f7 == 7'b0100000)
					aluOp = ALU_SRA;
				else if (f3 == 3'b101 && f7 != 7'b0000000)
					illegal = 1'b1;
			end
			OPC_LUI: begin
				aluSrcImm = 1'b1;
				regWrite = 1'b1;
				imm = immU;
				aluOp = ALU_PASSB;
			end
			OPC_LOAD: begin
				useRs1 = 1'b1;
				aluSrcImm = 1'b1;
				memRead = 1'b1;
				imm = immI;
				case (f3)
					3'b000, 3'b100: memSize = MEM_B;
					3'b001, 3'b101: memSize = MEM_H;
					3'b010: memSize = MEM_W;
					default: illegal = 1'b1;
				endcase
			end
			OPC_STORE: begin
				useRs1 = 1'b1;
				useRs2 = 1'b1;
				aluSrcImm = 1'b1;
				memWrite = 1'b1;
				imm = immS;
				case (f3)
					3'b000: memSize = MEM_B;
					3'b001: memSize = MEM_H;
					3'b010: memSize = MEM_W;
					default: illegal = 1'b1;
				endcase
			end
			default: illegal = 1'b1;
		endcase

		// No side effects from a bad encoding
		if (illegal) begin
			regWrite = 1'b0;
			memRead = 1'b0;
			memWrite = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire CLK,
	input wire RSTn,
	input wire [4:0] ra1,
	input wire [4:0] ra2,
	output logic [31:0] rd1,
	output logic [31:0] rd2,
	input wire we,
	input wire [4:0] wa,
	input wire [31:0] wd
);

	// x0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (we && wa != 5'd0) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so decode sees a value committed on this edge
	always_comb begin
		if (ra1 == 5'd0)
			rd1 = 32'd0;
		else if (we && wa == ra1)
			rd1 = wd;
		else
			rd1 = regs[ra1];

		if (ra2 == 5'd0)
			rd2 = 32'd0;
		else if (we && wa == ra2)
			rd2 = wd;
		else
			rd2 = regs[ra2];
	end

endmodule

`default_nettype wire

// File: prIdEx.sv
`timescale 1ns/100ps
`default_nettype none

module prIdEx (
	input wire CLK,
	input wire RSTn,
	input wire advance,
	// From decode
	input wire validIn,
	input wire [4:0] rs1In, rs2In, rdIn,
	input wire [31:0] rd1In, rd2In,
	input wire [31:0] immIn,
	input wire rvCorePkg::aluOp_e aluOpIn,
	input wire aluSrcImmIn,
	input wire regWriteIn,
	input wire memReadIn,
	input wire memWriteIn,
	input wire rvCorePkg::memSize_e memSizeIn,
	// To execute
	output logic valid,
	output logic [4:0] rs1, rs2, rd,
	output logic [31:0] rd1, rd2,
	output logic [31:0] imm,
	output rvCorePkg::aluOp_e aluOp,
	output logic aluSrcImm,
	output logic regWrite,
	output logic memRead,
	output logic memWrite,
	output rvCorePkg::memSize_e memSize
);
	import rvCorePkg::*;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			valid <= 1'b0;
			rs1 <= 5'd0;
			rs2 <= 5'd0;
			rd <= 5'd0;
			rd1 <= 32'd0;
			rd2 <= 32'd0;
			imm <= 32'd0;
			aluOp <= ALU_ADD;
			aluSrcImm <= 1'b0;
			regWrite <= 1'b0;
			memRead <= 1'b0;
			memWrite <= 1'b0;
			memSize <= MEM_B;
		end else if (advance) begin
			valid <= validIn;
			rs1 <= rs1In;
			rs2 <= rs2In;
			rd <= rdIn;
			rd1 <= rd1In;
			rd2 <= rd2In;
			imm <= immIn;
			aluOp <= aluOpIn;
			aluSrcImm <= aluSrcImmIn;
			memSize <= memSizeIn;
			// A bubble must not write anything downstream
			regWrite <= validIn & regWriteIn;
			memRead <= validIn & memReadIn;
			memWrite <= validIn & memWriteIn;
		end
	end

endmodule

`default_nettype wire

// File: aluExecute.sv
`timescale 1ns/100ps
`default_nettype none

module aluExecute (
	input wire CLK,
	input wire RSTn,
	input wire advance,
	// ID/EX fields
	input wire valid,
	input wire [4:0] rs1, rs2, rd,
	input wire [31:0] rd1, rd2,
	input wire [31:0] imm,
	input wire rvCorePkg::aluOp_e aluOp,
	input wire aluSrcImm,
	input wire regWrite,
	input wire memRead,
	input wire memWrite,
	input wire rvCorePkg::memSize_e memSize,
	// EX/WB register
	output logic outValid,
	output logic [4:0] outRd,
	output logic [31:0] outResult,
	output logic outRegWrite,
	output logic outMemRead,
	output logic outMemWrite,
	output logic [3:0] outMemBe,
	output logic [31:0] outStoreData
);
	import rvCorePkg::*;

	logic fwdA, fwdB;
	logic [31:0] opA, rs2Val, opB;
	logic [4:0] shamt;
	logic [31:0] aluResult;
	logic [1:0] byteOfs;
	logic [3:0] memBe;

	// Forward from the instruction one ahead
	assign fwdA = outValid && outRegWrite && outRd != 5'd0 && outRd == rs1;
	assign fwdB = outValid && outRegWrite && outRd != 5'd0 && outRd == rs2;

	assign opA = fwdA ? outResult : rd1;
	assign rs2Val = fwdB ? outResult : rd2;
	assign opB = aluSrcImm ? imm : rs2Val;
	assign shamt = opB[4:0];

	always_comb begin
		case (aluOp)
			ALU_ADD: aluResult = opA + opB;
			ALU_SUB: aluResult = opA - opB;
			ALU_SLL: aluResult = opA << shamt;
			ALU_SLT: aluResult = {31'd0, $signed(opA) < $signed(opB)};
			ALU_SLTU: aluResult = {31'd0, opA < opB};
			ALU_XOR: aluResult = opA ^ opB;
			ALU_SRL: aluResult = opA >> shamt;
			ALU_SRA: aluResult = $unsigned($signed(opA) >>> shamt);
			ALU_OR: aluResult = opA | opB;
			ALU_AND: aluResult = opA & opB;
			ALU_PASSB: aluResult = opB;
			default: aluResult = 32'd0;
		endcase
	end

	// Loads and stores use the ADD result as address
	assign byteOfs = aluResult[1:0];

	always_comb begin
		case (memSize)
			MEM_B: memBe = 4'b0001 << byteOfs;
			MEM_H: memBe = 4'b0011 << byteOfs;
			default: memBe = 4'b1111;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			outValid <= 1'b0;
			outRegWrite <= 1'b0;
			outMemRead <= 1'b0;
			outMemWrite <= 1'b0;
			outMemBe <= 4'd0;
		end else if (advance) begin
			outValid <= valid;
			outRegWrite <= regWrite;
			outMemRead <= memRead;
			outMemWrite <= memWrite;
			outMemBe <= (memRead || memWrite) ? memBe : 4'd0;
		end
	end

	always_ff @(posedge CLK) begin
		if (advance) begin
			outRd <= rd;
			outResult <= aluResult;
			// Store data lands in the addressed byte lanes
			outStoreData <= rs2Val << {byteOfs, 3'b000};
		end
	end

endmodule

`default_nettype wire

// File: decodeExecuteTop.sv
`timescale 1ns/100ps
`default_nettype none

module decodeExecuteTop (
	input wire CLK,
	input wire RSTn,
	// Instruction stream
	input wire inValid,
	input wire [31:0] inInstr,
	output wire inReady,
	// Result stream
	output wire outValid,
	output wire [4:0] outRd,
	output wire [31:0] outResult,
	output wire outRegWrite,
	output wire outMemRead,
	output wire outMemWrite,
	output wire [3:0] outMemBe,
	output wire [31:0] outStoreData,
	input wire outReady
);
	import rvCorePkg::*;

	logic advance;
	logic rfWe;
	logic idValid;

	logic [4:0] idRs1, idRs2, idRd;
	logic [31:0] idImm;
	aluOp_e idAluOp;
	logic idAluSrcImm, idRegWrite, idMemRead, idMemWrite, idIllegal;
	memSize_e idMemSize;
	logic [31:0] rfRd1, rfRd2;

	logic exValid;
	logic [4:0] exRs1, exRs2, exRd;
	logic [31:0] exRd1, exRd2, exImm;
	aluOp_e exAluOp;
	logic exAluSrcImm, exRegWrite, exMemRead, exMemWrite;
	memSize_e exMemSize;

	// Whole pipe moves unless a held result is refused
	assign advance = !outValid || outReady;
	assign inReady = advance;

	// Bad encodings enter as bubbles
	assign idValid = inValid && !idIllegal;

	// Commit on the output transfer
	assign rfWe = outValid && outReady && outRegWrite;

	instrDecode i_instrDecode (
		.instr(inInstr),
		.rs1(idRs1),
		.rs2(idRs2),
		.rd(idRd),
		.imm(idImm),
		.aluOp(idAluOp),
		.aluSrcImm(idAluSrcImm),
		.regWrite(idRegWrite),
		.memRead(idMemRead),
		.memWrite(idMemWrite),
		.memSize(idMemSize),
		.illegal(idIllegal)
	);

	regFile i_regFile (
		.CLK(CLK),
		.RSTn(RSTn),
		.ra1(idRs1),
		.ra2(idRs2),
		.rd1(rfRd1),
		.rd2(rfRd2),
		.we(rfWe),
		.wa(outRd),
		.wd(outResult)
	);

	prIdEx i_prIdEx (
		.CLK(CLK),
		.RSTn(RSTn),
		.advance(advance),
		.validIn(idValid),
		.rs1In(idRs1),
		.rs2In(idRs2),
		.rdIn(idRd),
		.rd1In(rfRd1),
		.rd2In(rfRd2),
		.immIn(idImm),
		.aluOpIn(idAluOp),
		.aluSrcImmIn(idAluSrcImm),
		.regWriteIn(idRegWrite),
		.memReadIn(idMemRead),
		.memWriteIn(idMemWrite),
		.memSizeIn(idMemSize),
		.valid(exValid),
		.rs1(exRs1),
		.rs2(exRs2),
		.rd(exRd),
		.rd1(exRd1),
		.rd2(exRd2),
		.imm(exImm),
		.aluOp(exAluOp),
		.aluSrcImm(exAluSrcImm),
		.regWrite(exRegWrite),
		.memRead(exMemRead),
		.memWrite(exMemWrite),
		.memSize(exMemSize)
	);

	aluExecute i_aluExecute (
		.CLK(CLK),
		.RSTn(RSTn),
		.advance(advance),
		.valid(exValid),
		.rs1(exRs1),
		.rs2(exRs2),
		.rd(exRd),
		.rd1(exRd1),
		.rd2(exRd2),
		.imm(exImm),
		.aluOp(exAluOp),
		.aluSrcImm(exAluSrcImm),
		.regWrite(exRegWrite),
		.memRead(exMemRead),
		.memWrite(exMemWrite),
		.memSize(exMemSize),
		.outValid(outValid),
		.outRd(outRd),
		.outResult(outResult),
		.outRegWrite(outRegWrite),
		.outMemRead(outMemRead),
		.outMemWrite(outMemWrite),
		.outMemBe(outMemBe),
		.outStoreData(outStoreData)
	);

endmodule

`default_nettype wire

// File: tbDecodeExecute.sv
`timescale 1ns/100ps
`default_nettype none

module tbDecodeExecute;

	localparam int clkPeriod = 40;
	localparam int maxInstr = 200;
	localparam int cyclesPerInstr = 8;
	// Upper bound on run length with slack for reset and drains
	localparam int timeoutNs = (maxInstr * cyclesPerInstr + 100) * clkPeriod;

	localparam logic [6:0] opcOp = 7'b0110011;
	localparam logic [6:0] opcOpImm = 7'b0010011;
	localparam logic [6:0] opcLui = 7'b0110111;
	localparam logic [6:0] opcLoad = 7'b0000011;
	localparam logic [6:0] opcStore = 7'b0100011;

	typedef struct packed {
		logic [4:0] rd;
		logic [31:0] result;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic [3:0] be;
		logic [31:0] storeData;
	} resultEntry_t;

	logic CLK, RSTn;
	logic inValid, inReady, outReady;
	logic [31:0] inInstr;
	logic outValid, outRegWrite, outMemRead, outMemWrite;
	logic [4:0] outRd;
	logic [31:0] outResult, outStoreData;
	logic [3:0] outMemBe;

	integer seed;
	logic randomReady;
	logic [31:0] readyRand;
	int errors, checks, issued, received;
	logic [31:0] model [0:31];
	resultEntry_t expQ [$];
	resultEntry_t heldOut, expOut, gotOut;
	logic holdValid;

	decodeExecuteTop i_decodeExecuteTop (
		.CLK(CLK),
		.RSTn(RSTn),
		.inValid(inValid),
		.inInstr(inInstr),
		.inReady(inReady),
		.outValid(outValid),
		.outRd(outRd),
		.outResult(outResult),
		.outRegWrite(outRegWrite),
		.outMemRead(outMemRead),
		.outMemWrite(outMemWrite),
		.outMemBe(outMemBe),
		.outStoreData(outStoreData),
		.outReady(outReady)
	);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	// Sink readiness is random only during the back-pressure test
	initial begin
		outReady = 1'b1;
		forever begin
			@(posedge CLK);
			#1;
			if (randomReady) begin
				readyRand = $random(seed);
				outReady = readyRand[0];
			end else begin
				outReady = 1'b1;
			end
		end
	end

	initial begin
		#(timeoutNs);
		$display("Watchdog timeout after %0d ns, the pipeline stopped moving", timeoutNs);
		$display("Checks: %0d  Errors: %0d", checks, errors);
		$display("Test failures found");
		$finish;
	end

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// RV32I arithmetic by funct3 where alt selects SUB and SRA
	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: return (a >> b[4:0]) |
				((alt && a[31]) ? ~(32'hffffffff >> b[4:0]) : 32'd0);
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic resultEntry_t outputsNow();
		resultEntry_t e;
		e.rd = outRd;
		e.result = outResult;
		e.regWrite = outRegWrite;
		e.memRead = outMemRead;
		e.memWrite = outMemWrite;
		e.be = outMemBe;
		e.storeData = outStoreData;
		return e;
	endfunction

	task automatic checkValue(input string what, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
		end
	endtask

	task automatic compareEntry(input resultEntry_t exp, input resultEntry_t got);
		checkValue("result", got.result, exp.result);
		checkValue("regWrite/memRead/memWrite",
			{29'd0, got.regWrite, got.memRead, got.memWrite},
			{29'd0, exp.regWrite, exp.memRead, exp.memWrite});
		checkValue("byte enables", {28'd0, got.be}, {28'd0, exp.be});
		if (exp.regWrite)
			checkValue("rd", {27'd0, got.rd}, {27'd0, exp.rd});
		if (exp.memWrite)
			checkValue("store data", got.storeData, exp.storeData);
	endtask

	// Scoreboard samples mid-cycle where the handshake is stable
	always @(negedge CLK) begin
		if (!RSTn) begin
			gotOut = outputsNow();
			if (holdValid) begin
				checks++;
				assert (outValid && gotOut === heldOut) else begin
					errors++;
					$display("CHECK FAILED at %0t: outputs changed during a stall", $time);
				end
			end
			holdValid = outValid && !outReady;
			heldOut = gotOut;
			if (outValid && outReady) begin
				received++;
				checks++;
				assert (expQ.size() != 0) else begin
					errors++;
					$display("Output transfer at %0t with no instruction outstanding", $time);
				end
				if (expQ.size() != 0) begin
					expOut = expQ.pop_front();
					compareEntry(expOut, gotOut);
				end
			end
		end
	end

	// Entered and left a short delay after a rising edge
	task automatic issue(input logic [31:0] instr, input resultEntry_t exp);
		logic accepted;
		expQ.push_back(exp);
		issued++;
		inInstr = instr;
		inValid = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(negedge CLK);
			accepted = inReady;
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic idle(input int n);
		inValid = 1'b0;
		repeat (n) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic drain();
		inValid = 1'b0;
		while (expQ.size() != 0) begin
			@(posedge CLK);
			#1;
		end
	endtask

	task automatic sendAlu(input logic [31:0] instr, input logic [4:0] rd,
			input logic [31:0] value);
		resultEntry_t e;
		e = '0;
		e.rd = rd;
		e.result = value;
		e.regWrite = 1'b1;
		if (rd != 5'd0)
			model[rd] = value;
		issue(instr, e);
	endtask

	task automatic opR(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		sendAlu({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, opcOp}, rd,
			aluRef(f3, alt, model[rs1], model[rs2]));
	endtask

	task automatic opI(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [11:0] imm);
		logic [11:0] field;
		logic sra;
		sra = alt && f3 == 3'd5;
		// Shift immediates hold a shamt and the SRAI marker
		if (f3 == 3'd1 || f3 == 3'd5)
			field = {sra ? 7'h20 : 7'h00, imm[4:0]};
		else
			field = imm;
		sendAlu({field, rs1, f3, rd, opcOpImm}, rd,
			aluRef(f3, sra, model[rs1], sext12(field)));
	endtask

	task automatic opLui(input logic [4:0] rd, input logic [19:0] imm20);
		sendAlu({imm20, rd, opcLui}, rd, {imm20, 12'd0});
	endtask

	// rsd is rs2 for a store and rd for a load
	task automatic opMem(input logic isStore, input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rsd, input logic [11:0] imm);
		resultEntry_t e;
		logic [31:0] addr;
		logic [1:0] off;
		logic [31:0] instr;
		addr = model[rs1] + sext12(imm);
		off = addr[1:0];
		e = '0;
		e.result = addr;
		e.memRead = !isStore;
		e.memWrite = isStore;
		case (f3[1:0])
			2'd0: e.be = 4'b0001 << off;
			2'd1: e.be = 4'b0011 << off;
			default: e.be = 4'b1111;
		endcase
		if (isStore) begin
			e.storeData = model[rsd] << {off, 3'b000};
			instr = {imm[11:5], rsd, rs1, f3, imm[4:0], opcStore};
		end else begin
			instr = {imm, rs1, f3, rsd, opcLoad};
		end
		issue(instr, e);
	endtask

	task automatic resetTest();
		RSTn = 1'b1;
		inValid = 1'b0;
		for (int i = 0; i < 32; i++)
			model[i] = 32'd0;
		repeat (4) begin
			@(posedge CLK);
			#1;
			checkValue("outValid in reset", {31'd0, outValid}, 32'd0);
		end
		RSTn = 1'b0;
		@(posedge CLK);
		#1;
		checkValue("outValid after reset", {31'd0, outValid}, 32'd0);
		opR(3'd0, 1'b0, 5'd1, 5'd0, 5'd0);
		opR(3'd0, 1'b0, 5'd2, 5'd1, 5'd1);
		opR(3'd6, 1'b0, 5'd3, 5'd2, 5'd31);
		drain();
	endtask

	task automatic rTypeTest();
		logic [31:0] a, b;
		logic [3:0] f;
		repeat (3) begin
			a = $random(seed);
			b = $random(seed);
			opLui(5'd1, a[31:12]);
			opI(3'd0, 1'b0, 5'd1, 5'd1, a[11:0]);
			opLui(5'd2, b[31:12]);
			opI(3'd0, 1'b0, 5'd2, 5'd2, b[11:0]);
			for (f = 4'd0; f < 4'd8; f++)
				opR(f[2:0], 1'b0, 5'd10 + {2'b00, f[2:0]}, 5'd1, 5'd2);
			opR(3'd0, 1'b1, 5'd18, 5'd1, 5'd2);
			opR(3'd5, 1'b1, 5'd19, 5'd1, 5'd2);
		end
		drain();
	endtask

	// Negative immediates and a negative source for sign handling
	task automatic iTypeTest();
		opLui(5'd5, 20'h87654);
		opI(3'd0, 1'b0, 5'd5, 5'd5, 12'h321);
		opI(3'd0, 1'b0, 5'd6, 5'd5, 12'hfff);
		opI(3'd0, 1'b0, 5'd6, 5'd0, 12'h800);
		opI(3'd2, 1'b0, 5'd7, 5'd5, 12'hffb);
		opI(3'd3, 1'b0, 5'd8, 5'd5, 12'hfff);
		opI(3'd2, 1'b0, 5'd9, 5'd0, 12'hfff);
		opI(3'd4, 1'b0, 5'd10, 5'd5, 12'hf00);
		opI(3'd6, 1'b0, 5'd11, 5'd0, 12'hff0);
		opI(3'd7, 1'b0, 5'd12, 5'd5, 12'hff8);
		opI(3'd1, 1'b0, 5'd13, 5'd5, 12'd4);
		opI(3'd5, 1'b0, 5'd14, 5'd5, 12'd7);
		opI(3'd5, 1'b1, 5'd15, 5'd5, 12'd7);
		opI(3'd5, 1'b1, 5'd16, 5'd5, 12'd31);
		opLui(5'd17, 20'hfffff);
		opI(3'd5, 1'b1, 5'd18, 5'd17, 12'd12);
		drain();
	endtask

	task automatic forwardTest();
		opI(3'd0, 1'b0, 5'd6, 5'd0, 12'd5);
		opI(3'd0, 1'b0, 5'd6, 5'd6, 12'd3);
		opR(3'd0, 1'b0, 5'd7, 5'd6, 5'd6);
		opR(3'd0, 1'b1, 5'd8, 5'd7, 5'd6);
		// Distance 2 goes through the register file bypass
		opI(3'd0, 1'b0, 5'd9, 5'd0, 12'h7ff);
		opI(3'd0, 1'b0, 5'd20, 5'd0, 12'd1);
		opR(3'd0, 1'b0, 5'd10, 5'd9, 5'd9);
		opI(3'd0, 1'b0, 5'd11, 5'd0, 12'hffd);
		opI(3'd0, 1'b0, 5'd21, 5'd0, 12'd2);
		opI(3'd0, 1'b0, 5'd22, 5'd0, 12'd3);
		opR(3'd2, 1'b0, 5'd12, 5'd11, 5'd21);
		opI(3'd0, 1'b0, 5'd0, 5'd0, 12'h123);
		opR(3'd0, 1'b0, 5'd13, 5'd0, 5'd0);
		opR(3'd0, 1'b0, 5'd14, 5'd0, 5'd6);
		opI(3'd0, 1'b0, 5'd15, 5'd0, 12'd9);
		idle(2);
		opR(3'd0, 1'b0, 5'd16, 5'd15, 5'd15);
		drain();
	endtask

	task automatic backPressureTest();
		logic [31:0] picks [0:39];
		logic [31:0] r;
		logic [2:0] f3;
		logic alt;
		int i;
		for (i = 0; i < 40; i++)
			picks[i] = $random(seed);
		randomReady = 1'b1;
		for (i = 0; i < 40; i++) begin
			r = picks[i];
			f3 = r[11:9];
			alt = r[12] && (f3 == 3'd5 || (r[13] && f3 == 3'd0));
			if (r[13])
				opR(f3, alt, {2'b00, r[2:0]} + 5'd1, {2'b00, r[5:3]} + 5'd1,
					{2'b00, r[8:6]} + 5'd1);
			else
				opI(f3, alt, {2'b00, r[2:0]} + 5'd1, {2'b00, r[5:3]} + 5'd1, r[31:20]);
		end
		drain();
		randomReady = 1'b0;
	endtask

	task automatic memTest();
		logic [3:0] off;
		opLui(5'd20, 20'h00001);
		opLui(5'd21, 20'ha1b2c);
		opI(3'd0, 1'b0, 5'd21, 5'd21, 12'h3d4);
		opI(3'd0, 1'b0, 5'd22, 5'd0, 12'd77);
		for (off = 4'd0; off < 4'd4; off++)
			opMem(1'b1, 3'b000, 5'd20, 5'd21, {8'd0, off});
		opMem(1'b1, 3'b001, 5'd20, 5'd21, 12'd0);
		opMem(1'b1, 3'b001, 5'd20, 5'd21, 12'd2);
		opMem(1'b1, 3'b010, 5'd20, 5'd21, 12'd0);
		opMem(1'b1, 3'b010, 5'd20, 5'd21, 12'hffc);
		for (off = 4'd0; off < 4'd4; off++)
			opMem(1'b0, 3'b000, 5'd20, 5'd22, {8'd0, off});
		opMem(1'b0, 3'b100, 5'd20, 5'd22, 12'd1);
		opMem(1'b0, 3'b001, 5'd20, 5'd22, 12'd2);
		opMem(1'b0, 3'b101, 5'd20, 5'd22, 12'd0);
		opMem(1'b0, 3'b010, 5'd20, 5'd22, 12'd8);
		opMem(1'b0, 3'b010, 5'd20, 5'd22, 12'hff8);
		// Loads never write back so x22 keeps its old value
		opR(3'd0, 1'b0, 5'd23, 5'd22, 5'd0);
		drain();
	endtask

	initial begin
		seed = 32'hb76dc4c9;
		RSTn = 1'b1;
		inValid = 1'b0;
		inInstr = 32'd0;
		randomReady = 1'b0;
		holdValid = 1'b0;
		errors = 0;
		checks = 0;
		issued = 0;
		received = 0;

		resetTest();
		rTypeTest();
		iTypeTest();
		forwardTest();
		backPressureTest();
		memTest();

		// Longer than the pipeline latency so a stray result still shows up
		idle(4);
		checks++;
		assert (received == issued) else begin
			errors++;
			$display("Instruction count mismatch: %0d issued, %0d received", issued, received);
		end
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
rvCorePkg.sv
instrDecode.sv
regFile.sv
prIdEx.sv
aluExecute.sv
decodeExecuteTop.sv
tbDecodeExecute.sv

// File: run.sh
#!/bin/bash
# Build and run the decode/execute testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/simDecodeExecute

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f \
	--top-module tbDecodeExecute \
	-o simDecodeExecute
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BIN" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
